/* Bender.yml */
package:
  name: uart_top

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_fifo.sv
      - hdl/uart_receiver.sv
      - hdl/uart_transmitter.sv
      - hdl/uart_apb_regs.sv
      - hdl/uart_top.sv

  - target: test
    files:
      - tests/uart_top_asserts.sv
      - tests/uart_top_tb.sv

/* hdl/uart_apb_regs.sv */
`timescale 1ns/1ps

module uart_apb_regs (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic                            i_psel,
	input  logic                            i_penable,
	input  logic                            i_pwrite,
	input  logic [uart_pkg::addr_width-1:0] i_paddr,
	input  logic [uart_pkg::data_width-1:0] i_pwdata,
	output logic [uart_pkg::data_width-1:0] o_prdata,
	output logic                            o_pready,
	output logic                            o_pslverr,
	input  logic                            i_rx_valid,
	input  uart_pkg::byte_t                 i_rx_byte,
	input  logic                            i_frame_error,
	output logic                            o_rx_push,
	output uart_pkg::byte_t                 o_rx_push_data,
	input  logic                            i_rx_empty,
	input  logic                            i_rx_full,
	output logic                            o_rx_pop,
	input  uart_pkg::byte_t                 i_rx_data,
	output logic                            o_tx_push,
	output uart_pkg::byte_t                 o_tx_push_data,
	input  logic                            i_tx_full,
	input  logic                            i_tx_busy,
	output logic                            o_interrupt
);

	logic access;
	logic read_access;
	logic write_access;
	logic sel_data;
	logic sel_status;
	logic sel_control;
	logic overrun;
	logic frame_error;
	logic irq_enable;

	// Zero wait states, every access completes in its access phase.
	assign access = i_psel && i_penable;
	assign read_access = access && !i_pwrite;
	assign write_access = access && i_pwrite;
	assign o_pready = access;

	assign sel_data = (i_paddr == uart_pkg::reg_data);
	assign sel_status = (i_paddr == uart_pkg::reg_status);
	assign sel_control = (i_paddr == uart_pkg::reg_control);

	// Unknown offset, read from an empty RX FIFO, or write to a full TX FIFO.
	assign o_pslverr = access && (!(sel_data || sel_status || sel_control) ||
		(sel_data && !i_pwrite && i_rx_empty) ||
		(sel_data && i_pwrite && i_tx_full));

	assign o_rx_pop = read_access && sel_data && !i_rx_empty;
	assign o_tx_push = write_access && sel_data && !i_tx_full;
	assign o_tx_push_data = i_pwdata[7:0];

	// No serial back-pressure, a byte that finds the FIFO full is lost.
	assign o_rx_push = i_rx_valid && !i_rx_full;
	assign o_rx_push_data = i_rx_byte;

	always_comb begin
		o_prdata = '0;
		if (read_access) begin
			if (sel_data) begin
				o_prdata[7:0] = i_rx_empty ? 8'h00 : i_rx_data;
			end else if (sel_status) begin
				o_prdata[uart_pkg::status_tx_full] = i_tx_full;
				o_prdata[uart_pkg::status_rx_empty] = i_rx_empty;
				o_prdata[uart_pkg::status_overrun] = overrun;
				o_prdata[uart_pkg::status_frame_error] = frame_error;
				o_prdata[uart_pkg::status_tx_busy] = i_tx_busy;
			end else if (sel_control) begin
				o_prdata[uart_pkg::control_irq_enable] = irq_enable;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			overrun <= 1'b0;
			frame_error <= 1'b0;
			irq_enable <= 1'b0;
			o_interrupt <= 1'b0;
		end else begin
			// Clear on STATUS read; a new event in the same cycle wins.
			if (read_access && sel_status) begin
				overrun <= 1'b0;
				frame_error <= 1'b0;
			end
			if (i_rx_valid && i_rx_full) begin
				overrun <= 1'b1;
			end
			if (i_frame_error) begin
				frame_error <= 1'b1;
			end
			if (write_access && sel_control) begin
				irq_enable <= i_pwdata[uart_pkg::control_irq_enable];
			end
			o_interrupt <= irq_enable && !i_rx_empty;
		end
	end

endmodule

/* hdl/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic           i_clock,
	input  logic           i_reset,
	input  logic           i_push,
	input  uart_pkg::byte_t i_push_data,
	input  logic           i_pop,
	output uart_pkg::byte_t o_pop_data,
	output logic           o_empty,
	output logic           o_full
);

	localparam int addr_bits = $clog2(FIFO_DEPTH);

	uart_pkg::byte_t memory [FIFO_DEPTH];

	// One extra bit on each pointer tells full from empty.
	logic [addr_bits:0] write_pointer;
	logic [addr_bits:0] read_pointer;
	logic               do_push;
	logic               do_pop;

	assign o_empty = (write_pointer == read_pointer);
	assign o_full = (write_pointer[addr_bits] != read_pointer[addr_bits]) &&
		(write_pointer[addr_bits-1:0] == read_pointer[addr_bits-1:0]);

	// Requests that cannot be served are ignored.
	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	// Oldest entry, shown without waiting for a pop.
	assign o_pop_data = memory[read_pointer[addr_bits-1:0]];

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			memory[write_pointer[addr_bits-1:0]] <= i_push_data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
		end else begin
			if (do_push) begin
				write_pointer <= write_pointer + 1'b1;
			end
			if (do_pop) begin
				read_pointer <= read_pointer + 1'b1;
			end
		end
	end

endmodule

/* hdl/uart_pkg.sv */
package uart_pkg;

	// APB bus widths.
	localparam int addr_width = 4;
	localparam int data_width = 32;

	// One serial character, 8N1.
	typedef logic [7:0] byte_t;

	// Register byte offsets.
	localparam logic [addr_width-1:0] reg_data = 4'd0;
	localparam logic [addr_width-1:0] reg_status = 4'd4;
	localparam logic [addr_width-1:0] reg_control = 4'd8;

	// STATUS bit positions.
	// Overrun and frame error are sticky and clear on a STATUS read.
	localparam int status_tx_full = 0;
	localparam int status_rx_empty = 1;
	localparam int status_overrun = 2;
	localparam int status_frame_error = 3;
	localparam int status_tx_busy = 4;

	// CONTROL bit positions.
	localparam int control_irq_enable = 0;

endpackage

/* hdl/uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input  logic            i_clock,
	input  logic            i_reset,
	input  logic            i_uart_rx,
	output logic            o_rx_valid,
	output uart_pkg::byte_t o_rx_byte,
	output logic            o_frame_error
);

	localparam int count_width = $clog2(CLOCKS_PER_BIT);
	localparam logic [count_width-1:0] full_bit = count_width'(CLOCKS_PER_BIT - 1);
	localparam logic [count_width-1:0] half_bit = count_width'(CLOCKS_PER_BIT / 2 - 1);

	localparam logic [1:0] state_idle = 2'd0;
	localparam logic [1:0] state_start = 2'd1;
	localparam logic [1:0] state_data = 2'd2;
	localparam logic [1:0] state_stop = 2'd3;

	logic                   rx_meta;
	logic                   rx_sync;
	logic [1:0]             state;
	logic [count_width-1:0] count;
	logic [2:0]             bit_index;
	logic                   sample;
	uart_pkg::byte_t        shift_reg;

	// Two flops against metastability; the line idles high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_uart_rx;
			rx_sync <= rx_meta;
		end
	end

	// Mid-bit sample point.
	assign sample = (count == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= state_idle;
			count <= '0;
			bit_index <= '0;
			o_rx_valid <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			o_frame_error <= 1'b0;
			if (state != state_idle && !sample) begin
				count <= count - 1'b1;
			end else begin
				case (state)
					state_idle: begin
						// Falling edge, wait half a bit.
						if (!rx_sync) begin
							state <= state_start;
							count <= half_bit;
						end
					end
					state_start: begin
						// A start bit gone high by its middle is a glitch.
						if (!rx_sync) begin
							state <= state_data;
							count <= full_bit;
							bit_index <= '0;
						end else begin
							state <= state_idle;
						end
					end
					state_data: begin
						count <= full_bit;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= state_stop;
						end
					end
					default: begin
						// Stop bit must be high, or the byte is dropped.
						o_rx_valid <= rx_sync;
						o_frame_error <= !rx_sync;
						state <= state_idle;
					end
				endcase
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge i_clock) begin
		if (state == state_data && sample) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
	end

	assign o_rx_byte = shift_reg;

endmodule

/* hdl/uart_top.sv */
`timescale 1ns/1ps

module uart_top #(
	parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic                            i_psel,
	input  logic                            i_penable,
	input  logic                            i_pwrite,
	input  logic [uart_pkg::addr_width-1:0] i_paddr,
	input  logic [uart_pkg::data_width-1:0] i_pwdata,
	output logic [uart_pkg::data_width-1:0] o_prdata,
	output logic                            o_pready,
	output logic                            o_pslverr,
	output logic                            o_interrupt,
	input  logic                            i_uart_rx,
	output logic                            o_uart_tx
);

	// Receive path.
	logic            rx_valid;
	uart_pkg::byte_t rx_byte;
	logic            rx_frame_error;
	logic            rx_push;
	uart_pkg::byte_t rx_push_data;
	logic            rx_pop;
	uart_pkg::byte_t rx_data;
	logic            rx_empty;
	logic            rx_full;

	// Transmit path.
	logic            tx_push;
	uart_pkg::byte_t tx_push_data;
	logic            tx_pop;
	uart_pkg::byte_t tx_data;
	logic            tx_empty;
	logic            tx_full;
	logic            tx_busy;

	uart_apb_regs uart_apb_regs_inst (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_psel         (i_psel),
		.i_penable      (i_penable),
		.i_pwrite       (i_pwrite),
		.i_paddr        (i_paddr),
		.i_pwdata       (i_pwdata),
		.o_prdata       (o_prdata),
		.o_pready       (o_pready),
		.o_pslverr      (o_pslverr),
		.i_rx_valid     (rx_valid),
		.i_rx_byte      (rx_byte),
		.i_frame_error  (rx_frame_error),
		.o_rx_push      (rx_push),
		.o_rx_push_data (rx_push_data),
		.i_rx_empty     (rx_empty),
		.i_rx_full      (rx_full),
		.o_rx_pop       (rx_pop),
		.i_rx_data      (rx_data),
		.o_tx_push      (tx_push),
		.o_tx_push_data (tx_push_data),
		.i_tx_full      (tx_full),
		.i_tx_busy      (tx_busy),
		.o_interrupt    (o_interrupt)
	);

	uart_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) rx_fifo (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_push      (rx_push),
		.i_push_data (rx_push_data),
		.i_pop       (rx_pop),
		.o_pop_data  (rx_data),
		.o_empty     (rx_empty),
		.o_full      (rx_full)
	);

	uart_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) tx_fifo (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_push      (tx_push),
		.i_push_data (tx_push_data),
		.i_pop       (tx_pop),
		.o_pop_data  (tx_data),
		.o_empty     (tx_empty),
		.o_full      (tx_full)
	);

	uart_receiver #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) uart_receiver_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_uart_rx     (i_uart_rx),
		.o_rx_valid    (rx_valid),
		.o_rx_byte     (rx_byte),
		.o_frame_error (rx_frame_error)
	);

	uart_transmitter #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) uart_transmitter_inst (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_fifo_empty (tx_empty),
		.i_fifo_data  (tx_data),
		.o_fifo_pop   (tx_pop),
		.o_uart_tx    (o_uart_tx),
		.o_busy       (tx_busy)
	);

endmodule

/* hdl/uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input  logic            i_clock,
	input  logic            i_reset,
	input  logic            i_fifo_empty,
	input  uart_pkg::byte_t i_fifo_data,
	output logic            o_fifo_pop,
	output logic            o_uart_tx,
	output logic            o_busy
);

	localparam int count_width = $clog2(CLOCKS_PER_BIT);
	localparam logic [count_width-1:0] full_bit = count_width'(CLOCKS_PER_BIT - 1);

	logic                   busy;
	logic [count_width-1:0] count;
	logic [3:0]             bit_index;
	logic [9:0]             shifter;
	logic                   frame_done;
	logic                   load;

	// Last cycle of the stop bit.
	assign frame_done = busy && (count == '0) && (bit_index == 4'd9);

	// Loading on the last stop-bit cycle keeps queued frames back to back.
	assign load = !i_fifo_empty && (!busy || frame_done);
	assign o_fifo_pop = load;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
			bit_index <= '0;
			shifter <= '1;
		end else if (load) begin
			// Stop bit, data LSB first, start bit.
			shifter <= {1'b1, i_fifo_data, 1'b0};
			busy <= 1'b1;
			count <= full_bit;
			bit_index <= '0;
		end else if (busy) begin
			if (count != '0) begin
				count <= count - 1'b1;
			end else if (bit_index == 4'd9) begin
				busy <= 1'b0;
			end else begin
				// Ones fill in behind, so the line returns high.
				shifter <= {1'b1, shifter[9:1]};
				bit_index <= bit_index + 1'b1;
				count <= full_bit;
			end
		end
	end

	assign o_uart_tx = shifter[0];
	assign o_busy = busy;

endmodule

/* tests/uart_top_asserts.sv */
`timescale 1ns/1ps

module uart_top_asserts (
	input logic                            i_clock,
	input logic                            i_reset,
	input logic                            i_psel,
	input logic                            i_penable,
	input logic                            i_pwrite,
	input logic [uart_pkg::addr_width-1:0] i_paddr,
	input logic [uart_pkg::data_width-1:0] i_pwdata,
	input logic                            o_pready,
	input logic                            o_pslverr,
	input logic                            o_interrupt,
	input logic                            o_uart_tx
);

	logic irq_seen;

	// CONTROL irq_enable as seen from completed APB writes.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			irq_seen <= 1'b0;
		end else if (i_psel && i_penable && i_pwrite && i_paddr == uart_pkg::reg_control) begin
			irq_seen <= i_pwdata[uart_pkg::control_irq_enable];
		end
	end

	pready_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
		o_pready |-> (i_psel && i_penable))
		else $error("pready outside an APB access phase");

	pslverr_with_pready: assert property (@(posedge i_clock) disable iff (i_reset)
		o_pslverr |-> o_pready)
		else $error("pslverr without pready");

	// Covers the first cycle after reset is released too.
	reset_outputs: assert property (@(posedge i_clock)
		i_reset |=> (o_uart_tx && !o_interrupt))
		else $error("tx line or interrupt not at the reset level");

	irq_needs_enable: assert property (@(posedge i_clock) disable iff (i_reset)
		!irq_seen |=> !$rose(o_interrupt))
		else $error("interrupt rose while irq_enable was clear");

endmodule

bind uart_top uart_top_asserts uart_top_asserts_inst (
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_psel      (i_psel),
	.i_penable   (i_penable),
	.i_pwrite    (i_pwrite),
	.i_paddr     (i_paddr),
	.i_pwdata    (i_pwdata),
	.o_pready    (o_pready),
	.o_pslverr   (o_pslverr),
	.o_interrupt (o_interrupt),
	.o_uart_tx   (o_uart_tx)
);

/* tests/uart_top_tb.sv */
`timescale 1ns/1ps

module uart_top_tb;

	localparam int clocks_per_bit = 16;
	localparam int fifo_depth = 8;
	localparam int clock_period = 8;
	localparam int reset_cycles = 16;
	// An 8N1 frame is ten bit times.
	localparam int frame_time = 10 * clocks_per_bit * clock_period;
	localparam int timeout_time = 40 * frame_time + reset_cycles * clock_period;

	logic                            i_clock;
	logic                            i_reset;
	logic                            i_psel;
	logic                            i_penable;
	logic                            i_pwrite;
	logic [uart_pkg::addr_width-1:0] i_paddr;
	logic [uart_pkg::data_width-1:0] i_pwdata;
	logic [uart_pkg::data_width-1:0] o_prdata;
	logic                            o_pready;
	logic                            o_pslverr;
	logic                            o_interrupt;
	logic                            i_uart_rx;
	logic                            o_uart_tx;

	logic                            loopback;
	logic                            serial_line;
	int                              errors;
	int                              checks;
	integer                          seed;
	uart_pkg::byte_t                 sent[$];
	uart_pkg::byte_t                 captured[$];
	logic [uart_pkg::data_width-1:0] rdata;
	logic                            slverr;

	// Receive input comes from the transmitter or from the serial driver.
	assign i_uart_rx = loopback ? o_uart_tx : serial_line;

	uart_top #(
		.CLOCKS_PER_BIT (clocks_per_bit),
		.FIFO_DEPTH     (fifo_depth)
	) uart_top_inst (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_interrupt (o_interrupt),
		.i_uart_rx   (i_uart_rx),
		.o_uart_tx   (o_uart_tx)
	);

	always #(clock_period / 2) i_clock = ~i_clock;

	task automatic check_bit(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_byte(input uart_pkg::byte_t actual, input uart_pkg::byte_t expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_word(input logic [uart_pkg::data_width-1:0] actual,
			input logic [uart_pkg::data_width-1:0] expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Setup phase, then access phase sampled on the falling edge.
	task automatic apb_access(input logic write, input logic [uart_pkg::addr_width-1:0] addr,
			input logic [uart_pkg::data_width-1:0] wdata,
			output logic [uart_pkg::data_width-1:0] data, output logic error);
		int waited;
		waited = 0;
		@(posedge i_clock);
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= write;
		i_paddr <= addr;
		i_pwdata <= wdata;
		@(posedge i_clock);
		i_penable <= 1'b1;
		@(negedge i_clock);
		while (!o_pready && waited < 16) begin
			@(negedge i_clock);
			waited++;
		end
		if (!o_pready) begin
			errors++;
			$display("APB access to offset %0d never got a ready response", addr);
		end
		data = o_prdata;
		error = o_pslverr;
		@(posedge i_clock);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [uart_pkg::addr_width-1:0] addr,
			input logic [uart_pkg::data_width-1:0] wdata, output logic error);
		logic [uart_pkg::data_width-1:0] unused;
		apb_access(1'b1, addr, wdata, unused, error);
	endtask

	task automatic apb_read(input logic [uart_pkg::addr_width-1:0] addr,
			output logic [uart_pkg::data_width-1:0] data, output logic error);
		apb_access(1'b0, addr, '0, data, error);
	endtask

	// Start bit, data LSB first, chosen stop bit, then one idle bit time.
	task automatic serial_send(input uart_pkg::byte_t data, input logic stop_bit);
		logic [9:0] frame;
		int i;
		frame = {stop_bit, data, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge i_clock);
			serial_line <= (i < 10) ? frame[i] : 1'b1;
			repeat (clocks_per_bit - 1) @(posedge i_clock);
		end
	endtask

	task automatic serial_capture(input int count);
		uart_pkg::byte_t data;
		int frame;
		int b;
		int waited;
		for (frame = 0; frame < count; frame++) begin
			waited = 0;
			@(negedge i_clock);
			while (o_uart_tx && waited < 40 * clocks_per_bit) begin
				@(negedge i_clock);
				waited++;
			end
			if (o_uart_tx) begin
				errors++;
				$display("No start bit appeared on the transmit line");
				return;
			end
			repeat (clocks_per_bit / 2) @(negedge i_clock);
			check_bit(o_uart_tx, 1'b0, "tx start bit");
			for (b = 0; b < 8; b++) begin
				repeat (clocks_per_bit) @(negedge i_clock);
				data[b] = o_uart_tx;
			end
			repeat (clocks_per_bit) @(negedge i_clock);
			check_bit(o_uart_tx, 1'b1, "tx stop bit");
			captured.push_back(data);
		end
	endtask

	task automatic wait_rx_ready();
		logic [uart_pkg::data_width-1:0] status;
		logic error;
		int polls;
		polls = 0;
		status = '1;
		while (status[uart_pkg::status_rx_empty] && polls < 1000) begin
			apb_read(uart_pkg::reg_status, status, error);
			polls++;
		end
		if (status[uart_pkg::status_rx_empty]) begin
			errors++;
			$display("The receive FIFO stayed empty while waiting for a byte");
		end
	endtask

	task automatic reset_state();
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_word(rdata, 32'd1 << uart_pkg::status_rx_empty, "STATUS after reset");
		apb_read(uart_pkg::reg_control, rdata, slverr);
		check_word(rdata, '0, "CONTROL after reset");
		@(negedge i_clock);
		check_bit(o_uart_tx, 1'b1, "tx line after reset");
	endtask

	task automatic loopback_order();
		uart_pkg::byte_t data;
		int i;
		sent.delete();
		captured.delete();
		@(posedge i_clock);
		loopback <= 1'b1;
		fork
			serial_capture(5);
			begin
				for (i = 0; i < 5; i++) begin
					data = uart_pkg::byte_t'($random(seed));
					sent.push_back(data);
					apb_write(uart_pkg::reg_data, {24'h0, data}, slverr);
					check_bit(slverr, 1'b0, "pslverr on DATA write");
				end
				for (i = 0; i < 5; i++) begin
					wait_rx_ready();
					apb_read(uart_pkg::reg_data, rdata, slverr);
					check_bit(slverr, 1'b0, "pslverr on DATA read");
					check_byte(rdata[7:0], sent[i], "looped back byte");
				end
			end
		join
		check_word(captured.size(), 5, "captured frame count");
		for (i = 0; i < 5 && i < captured.size(); i++) begin
			check_byte(captured[i], sent[i], "byte decoded on tx line");
		end
		@(posedge i_clock);
		loopback <= 1'b0;
	endtask

	task automatic overrun_drop();
		uart_pkg::byte_t data;
		int i;
		sent.delete();
		for (i = 0; i < fifo_depth + 2; i++) begin
			data = uart_pkg::byte_t'($random(seed));
			sent.push_back(data);
			serial_send(data, 1'b1);
		end
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_bit(rdata[uart_pkg::status_overrun], 1'b1, "overrun after a full FIFO");
		check_bit(rdata[uart_pkg::status_rx_empty], 1'b0, "rx_empty with stored bytes");
		for (i = 0; i < fifo_depth; i++) begin
			apb_read(uart_pkg::reg_data, rdata, slverr);
			check_bit(slverr, 1'b0, "pslverr on stored byte");
			check_word(rdata, {24'h0, sent[i]}, "stored byte");
		end
		apb_read(uart_pkg::reg_data, rdata, slverr);
		check_bit(slverr, 1'b1, "pslverr past the stored bytes");
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_bit(rdata[uart_pkg::status_overrun], 1'b0, "overrun after STATUS read");
		check_bit(rdata[uart_pkg::status_rx_empty], 1'b1, "rx_empty after draining");
	endtask

	task automatic framing_error();
		serial_send(uart_pkg::byte_t'($random(seed)), 1'b0);
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_bit(rdata[uart_pkg::status_frame_error], 1'b1, "frame_error after low stop");
		check_bit(rdata[uart_pkg::status_rx_empty], 1'b1, "rx_empty after bad frame");
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_bit(rdata[uart_pkg::status_frame_error], 1'b0, "frame_error after STATUS read");
	endtask

	task automatic interrupt_level();
		uart_pkg::byte_t data;
		data = uart_pkg::byte_t'($random(seed));
		serial_send(data, 1'b1);
		wait_rx_ready();
		// The interrupt is registered, so it follows CONTROL one cycle later.
		repeat (2) @(negedge i_clock);
		check_bit(o_interrupt, 1'b0, "interrupt while disabled");
		apb_write(uart_pkg::reg_control, 32'd1 << uart_pkg::control_irq_enable, slverr);
		repeat (2) @(negedge i_clock);
		check_bit(o_interrupt, 1'b1, "interrupt once enabled");
		apb_read(uart_pkg::reg_control, rdata, slverr);
		check_word(rdata, 32'd1 << uart_pkg::control_irq_enable, "CONTROL readback");
		apb_read(uart_pkg::reg_data, rdata, slverr);
		check_byte(rdata[7:0], data, "byte behind the interrupt");
		repeat (2) @(negedge i_clock);
		check_bit(o_interrupt, 1'b0, "interrupt after reading the byte");
		apb_write(uart_pkg::reg_control, '0, slverr);
	endtask

	task automatic error_responses();
		int i;
		apb_read(4'd12, rdata, slverr);
		check_bit(slverr, 1'b1, "pslverr on read of offset 12");
		check_word(rdata, '0, "read data of offset 12");
		apb_write(4'd12, 32'h5a, slverr);
		check_bit(slverr, 1'b1, "pslverr on write of offset 12");
		apb_read(uart_pkg::reg_data, rdata, slverr);
		check_bit(slverr, 1'b1, "pslverr on DATA read when empty");
		check_word(rdata, '0, "DATA read when empty");
		// The transmitter takes the first byte at once and the rest fill the FIFO.
		for (i = 0; i < fifo_depth + 1; i++) begin
			apb_write(uart_pkg::reg_data, 32'(i), slverr);
			check_bit(slverr, 1'b0, "pslverr while filling the TX FIFO");
		end
		apb_read(uart_pkg::reg_status, rdata, slverr);
		check_bit(rdata[uart_pkg::status_tx_full], 1'b1, "tx_full after filling");
		check_bit(rdata[uart_pkg::status_tx_busy], 1'b1, "tx_busy while sending");
		apb_write(uart_pkg::reg_data, 32'hff, slverr);
		check_bit(slverr, 1'b1, "pslverr on DATA write when full");
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'h937c239f;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		loopback = 1'b0;
		serial_line = 1'b1;
		repeat (reset_cycles) @(posedge i_clock);
		i_reset <= 1'b0;
		reset_state();
		loopback_order();
		overrun_drop();
		framing_error();
		interrupt_level();
		error_responses();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		#(timeout_time);
		$display("Timeout: the tests did not finish within %0d ns", timeout_time);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* uart_top.f */
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_receiver.sv
hdl/uart_transmitter.sv
hdl/uart_apb_regs.sv
hdl/uart_top.sv
tests/uart_top_asserts.sv
tests/uart_top_tb.sv
